// File: Makefile
VERILATOR ?= verilator
TOP       ?= ctrl_unit_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall

SRCS := $(shell grep -v '^+' $(FILELIST)) include/ctrl_params.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then echo "no verdict in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: build.f
+incdir+include
design/ctrl_pkg.sv
design/main_decoder.sv
design/funct_decoder.sv
design/alu_decoder.sv
design/ctrl_unit.sv
tb/ctrl_unit_tb.sv

// File: tb/ctrl_unit_tb.sv
`include "ctrl_params.svh"

module ctrl_unit_tb;
        timeunit 1ns;
        timeprecision 1ps;

        localparam int NUM_VEC     = 54;
        localparam int NUM_STROBES = 26;
        localparam int MAX_CYCLES  = 3 + 2 * NUM_VEC + 10; // reset, vectors, slack

        typedef struct packed {
                logic [`CTRL_OPCODE_W-1:0]   opcode;
                logic [`CTRL_FUNCT_W-1:0]    funct;
                logic                        funct_dc; // drive funct from the lfsr
                logic [NUM_STROBES-1:0]      strobes;
                logic [`CTRL_ALU_CTRL_W-1:0] alu_control;
        } vec_t;

        logic clk;
        logic rst_n;
        logic [`CTRL_OPCODE_W-1:0] opcode;
        logic [`CTRL_FUNCT_W-1:0] funct;
        logic reg_write, reg_dst, alu_src, branch;
        logic mem_write, mem_to_reg, jump, jump_rt;
        logic lb, lbu, lh, lhu, sb, sh;
        logic mfhi, mflo, mthi, mtlo;
        logic mult, multu, div, divu;
        logic syscall, brk, undefined_instr, overflow_check;
        logic [`CTRL_ALU_CTRL_W-1:0] alu_control;
        logic [NUM_STROBES-1:0] strobes;
        logic [31:0] lfsr;
        int cycles = 0;
        int n_pass;
        int n_fail;

        // indexed msb first like the strobes vector
        string strobe_names [NUM_STROBES] = '{
                "reg_write", "reg_dst", "alu_src", "branch", "mem_write", "mem_to_reg",
                "jump", "jump_rt", "lb", "lbu", "lh", "lhu", "sb", "sh",
                "mfhi", "mflo", "mthi", "mtlo", "mult", "multu", "div", "divu",
                "syscall", "brk", "undefined_instr", "overflow_check"
        };

        ctrl_unit UUT (.*);

        assign strobes = {reg_write, reg_dst, alu_src, branch, mem_write, mem_to_reg, jump,
                          jump_rt, lb, lbu, lh, lhu, sb, sh, mfhi, mflo, mthi, mtlo, mult,
                          multu, div, divu, syscall, brk, undefined_instr, overflow_check};

        initial clk = 1'b0;
        always #20 clk = ~clk;

        // strobe column groups
        // rw rd asrc br mw m2r j jrt | lb lbu lh lhu sb sh
        // mfhi mflo mthi mtlo mult multu div divu | sys brk undef ovf
        function automatic vec_t vector_at(input int idx);
                vec_t v;
                v = '0;
                case (idx)
                        // lw lb lbu lh lhu sw sb sh
                        0:  v = {6'h23, 6'h00, 1'b1, 26'b10100100_000000_00000000_0000, 4'h2};
                        1:  v = {6'h20, 6'h00, 1'b1, 26'b10100100_100000_00000000_0000, 4'h2};
                        2:  v = {6'h24, 6'h00, 1'b1, 26'b10100100_010000_00000000_0000, 4'h2};
                        3:  v = {6'h21, 6'h00, 1'b1, 26'b10100100_001000_00000000_0000, 4'h2};
                        4:  v = {6'h25, 6'h00, 1'b1, 26'b10100100_000100_00000000_0000, 4'h2};
                        5:  v = {6'h2b, 6'h00, 1'b1, 26'b00101000_000000_00000000_0000, 4'h2};
                        6:  v = {6'h28, 6'h00, 1'b1, 26'b00101000_000010_00000000_0000, 4'h2};
                        7:  v = {6'h29, 6'h00, 1'b1, 26'b00101000_000001_00000000_0000, 4'h2};
                        // addi addiu lui andi ori xori slti sltiu
                        8:  v = {6'h08, 6'h00, 1'b1, 26'b10100000_000000_00000000_0000, 4'h2};
                        9:  v = {6'h09, 6'h00, 1'b1, 26'b10100000_000000_00000000_0000, 4'h2};
                        10: v = {6'h0f, 6'h00, 1'b1, 26'b10100000_000000_00000000_0000, 4'h2};
                        11: v = {6'h0c, 6'h00, 1'b1, 26'b10100000_000000_00000000_0000, 4'h0};
                        12: v = {6'h0d, 6'h00, 1'b1, 26'b10100000_000000_00000000_0000, 4'h1};
                        13: v = {6'h0e, 6'h00, 1'b1, 26'b10100000_000000_00000000_0000, 4'h4};
                        14: v = {6'h0a, 6'h00, 1'b1, 26'b10100000_000000_00000000_0000, 4'h7};
                        15: v = {6'h0b, 6'h00, 1'b1, 26'b10100000_000000_00000000_0000, 4'h8};
                        // beq bne regimm blez bgtz j jal
                        16: v = {6'h04, 6'h00, 1'b1, 26'b00010000_000000_00000000_0000, 4'h6};
                        17: v = {6'h05, 6'h00, 1'b1, 26'b00010000_000000_00000000_0000, 4'h6};
                        18: v = {6'h01, 6'h00, 1'b1, 26'b00010000_000000_00000000_0000, 4'h6};
                        19: v = {6'h06, 6'h00, 1'b1, 26'b00010000_000000_00000000_0000, 4'h6};
                        20: v = {6'h07, 6'h00, 1'b1, 26'b00010000_000000_00000000_0000, 4'h6};
                        21: v = {6'h02, 6'h00, 1'b1, 26'b00000010_000000_00000000_0000, 4'h2};
                        22: v = {6'h03, 6'h00, 1'b1, 26'b10000010_000000_00000000_0000, 4'h2};
                        // add addu sub subu and or xor nor slt sltu
                        23: v = {6'h00, 6'h20, 1'b0, 26'b11000000_000000_00000000_0001, 4'h2};
                        24: v = {6'h00, 6'h21, 1'b0, 26'b11000000_000000_00000000_0000, 4'h2};
                        25: v = {6'h00, 6'h22, 1'b0, 26'b11000000_000000_00000000_0001, 4'h6};
                        26: v = {6'h00, 6'h23, 1'b0, 26'b11000000_000000_00000000_0000, 4'h6};
                        27: v = {6'h00, 6'h24, 1'b0, 26'b11000000_000000_00000000_0000, 4'h0};
                        28: v = {6'h00, 6'h25, 1'b0, 26'b11000000_000000_00000000_0000, 4'h1};
                        29: v = {6'h00, 6'h26, 1'b0, 26'b11000000_000000_00000000_0000, 4'h4};
                        30: v = {6'h00, 6'h27, 1'b0, 26'b11000000_000000_00000000_0000, 4'h5};
                        31: v = {6'h00, 6'h2a, 1'b0, 26'b11000000_000000_00000000_0000, 4'h7};
                        32: v = {6'h00, 6'h2b, 1'b0, 26'b11000000_000000_00000000_0000, 4'h8};
                        // sll srl sra sllv srlv srav
                        33: v = {6'h00, 6'h00, 1'b0, 26'b11000000_000000_00000000_0000, 4'h9};
                        34: v = {6'h00, 6'h02, 1'b0, 26'b11000000_000000_00000000_0000, 4'ha};
                        35: v = {6'h00, 6'h03, 1'b0, 26'b11000000_000000_00000000_0000, 4'hb};
                        36: v = {6'h00, 6'h04, 1'b0, 26'b11000000_000000_00000000_0000, 4'hc};
                        37: v = {6'h00, 6'h06, 1'b0, 26'b11000000_000000_00000000_0000, 4'hd};
                        38: v = {6'h00, 6'h07, 1'b0, 26'b11000000_000000_00000000_0000, 4'he};
                        // jr jalr mfhi mthi mflo mtlo mult multu div divu syscall break
                        39: v = {6'h00, 6'h08, 1'b0, 26'b01000001_000000_00000000_0000, 4'h2};
                        40: v = {6'h00, 6'h09, 1'b0, 26'b11000001_000000_00000000_0000, 4'h2};
                        41: v = {6'h00, 6'h10, 1'b0, 26'b11000000_000000_10000000_0000, 4'h2};
                        42: v = {6'h00, 6'h11, 1'b0, 26'b11000000_000000_00100000_0000, 4'h2};
                        43: v = {6'h00, 6'h12, 1'b0, 26'b11000000_000000_01000000_0000, 4'h2};
                        44: v = {6'h00, 6'h13, 1'b0, 26'b11000000_000000_00010000_0000, 4'h2};
                        45: v = {6'h00, 6'h18, 1'b0, 26'b11000000_000000_00111000_0000, 4'h2};
                        46: v = {6'h00, 6'h19, 1'b0, 26'b11000000_000000_00110100_0000, 4'h2};
                        47: v = {6'h00, 6'h1a, 1'b0, 26'b11000000_000000_00110010_0000, 4'h2};
                        48: v = {6'h00, 6'h1b, 1'b0, 26'b11000000_000000_00110001_0000, 4'h2};
                        49: v = {6'h00, 6'h0c, 1'b0, 26'b11000000_000000_00000000_1000, 4'h2};
                        50: v = {6'h00, 6'h0d, 1'b0, 26'b11000000_000000_00000000_0100, 4'h2};
                        // unused opcodes
                        51: v = {6'h10, 6'h00, 1'b1, 26'b00000000_000000_00000000_0010, 4'h2};
                        52: v = {6'h3f, 6'h00, 1'b1, 26'b00000000_000000_00000000_0010, 4'h2};
                        53: v = {6'h31, 6'h00, 1'b1, 26'b00000000_000000_00000000_0010, 4'h2};
                        default: v = '0;
                endcase
                return v;
        endfunction

        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
        endfunction

        task automatic draw_funct(output logic [`CTRL_FUNCT_W-1:0] f);
                f = '0;
                for (int i = 0; i < `CTRL_FUNCT_W; i++) begin
                        lfsr = lfsr_next(lfsr); // one step per bit
                        f    = {f[`CTRL_FUNCT_W-2:0], lfsr[0]};
                end
        endtask

        task automatic check_vector(input int idx, input vec_t v);
                int errs;
                errs = 0;
                for (int b = NUM_STROBES - 1; b >= 0; b--) begin
                        if (strobes[b] !== v.strobes[b]) begin
                                $display("FAIL t=%0t vec %0d %s expected %b got %b", $time, idx,
                                         strobe_names[NUM_STROBES-1-b], v.strobes[b], strobes[b]);
                                errs++;
                        end
                end
                if (alu_control !== v.alu_control) begin
                        $display("FAIL t=%0t vec %0d alu_control expected %h got %h", $time, idx,
                                 v.alu_control, alu_control);
                        errs++;
                end
                if (errs == 0) begin
                        $display("PASS vec %0d opcode %h funct %h", idx, opcode, funct);
                        n_pass++;
                end else begin
                        n_fail++;
                end
        endtask

        initial begin
                rst_n = 1'b0;
                repeat (3) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1;
        end

        initial begin
                vec_t v;
                opcode = '0;
                funct  = '0;
                lfsr   = 32'h42d28697;
                n_pass = 0;
                n_fail = 0;
                @(posedge rst_n);

                for (int i = 0; i < NUM_VEC; i++) begin
                        @(negedge clk);
                        v      = vector_at(i);
                        opcode = v.opcode;
                        if (v.funct_dc) begin
                                draw_funct(funct);
                        end else begin
                                funct = v.funct;
                        end
                        @(posedge clk); // outputs settled half a period ago
                        check_vector(i, v);
                end

                $display("tests: %0d passed, %0d failed", n_pass, n_fail);
                if (n_fail == 0) begin
                        $display("Verification passed");
                end else begin
                        $display("Verification failed");
                end
                $finish;
        end

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycles >= MAX_CYCLES) begin
                        $display("timeout: vector loop still running after %0d cycles", cycles);
                        $display("Verification failed");
                        $finish;
                end
        end

endmodule

// File: design/ctrl_unit.sv
`include "ctrl_params.svh"

module ctrl_unit import ctrl_pkg::*; (
        input  logic [`CTRL_OPCODE_W-1:0]   opcode,
        input  logic [`CTRL_FUNCT_W-1:0]    funct,
        output logic                        reg_write,
        output logic                        reg_dst,
        output logic                        alu_src,
        output logic                        branch,
        output logic                        mem_write,
        output logic                        mem_to_reg,
        output logic                        jump,
        output logic                        jump_rt,
        output logic                        lb,
        output logic                        lbu,
        output logic                        lh,
        output logic                        lhu,
        output logic                        sb,
        output logic                        sh,
        output logic                        mfhi,
        output logic                        mflo,
        output logic                        mthi,
        output logic                        mtlo,
        output logic                        mult,
        output logic                        multu,
        output logic                        div,
        output logic                        divu,
        output logic                        syscall,
        output logic                        brk,
        output logic                        undefined_instr,
        output logic [`CTRL_ALU_CTRL_W-1:0] alu_control,
        output logic                        overflow_check
);

        opcode_e opcode_t;
        funct_e  funct_t;
        alu_op_e alu_op;
        imm_op_e imm_op;
        logic    r_type;
        logic    main_reg_write;
        logic    reg_write_block;

        assign opcode_t = opcode_e'(opcode);
        assign funct_t  = funct_e'(funct);

        main_decoder u_main_dec (
                .opcode          (opcode_t),
                .r_type          (r_type),
                .reg_write       (main_reg_write),
                .reg_dst         (reg_dst),
                .alu_src         (alu_src),
                .branch          (branch),
                .mem_write       (mem_write),
                .mem_to_reg      (mem_to_reg),
                .jump            (jump),
                .lb              (lb),
                .lbu             (lbu),
                .lh              (lh),
                .lhu             (lhu),
                .sb              (sb),
                .sh              (sh),
                .undefined_instr (undefined_instr),
                .alu_op          (alu_op),
                .imm_op          (imm_op)
        );

        funct_decoder u_funct_dec (
                .funct           (funct_t),
                .r_type          (r_type),
                .jump_rt         (jump_rt),
                .reg_write_block (reg_write_block),
                .mfhi            (mfhi),
                .mflo            (mflo),
                .mthi            (mthi),
                .mtlo            (mtlo),
                .mult            (mult),
                .multu           (multu),
                .div             (div),
                .divu            (divu),
                .syscall         (syscall),
                .brk             (brk)
        );

        alu_decoder u_alu_dec (
                .alu_op         (alu_op),
                .imm_op         (imm_op),
                .funct          (funct_t),
                .alu_control    (alu_control),
                .overflow_check (overflow_check)
        );

        assign reg_write = main_reg_write & ~reg_write_block; // jr writes nothing

endmodule

// File: design/alu_decoder.sv
module alu_decoder import ctrl_pkg::*; (
        input  alu_op_e   alu_op,
        input  imm_op_e   imm_op,
        input  funct_e    funct,
        output alu_ctrl_e alu_control,
        output logic      overflow_check
);

        always_comb begin
                alu_control    = ALU_ADD;
                overflow_check = 1'b0;

                if (imm_op != IMM_NONE) begin
                        case (imm_op)
                                IMM_AND:  alu_control = ALU_AND;
                                IMM_OR:   alu_control = ALU_OR;
                                IMM_XOR:  alu_control = ALU_XOR;
                                IMM_SLT:  alu_control = ALU_SLT;
                                IMM_SLTU: alu_control = ALU_SLTU;
                                default:  alu_control = ALU_ADD;
                        endcase
                end else begin
                        case (alu_op)
                                ALU_OP_ADD: alu_control = ALU_ADD;
                                ALU_OP_SUB: alu_control = ALU_SUB;
                                ALU_OP_RTYPE: begin
                                        case (funct)
                                                FN_ADD, FN_ADDU: alu_control = ALU_ADD;
                                                FN_SUB, FN_SUBU: alu_control = ALU_SUB;
                                                FN_AND:  alu_control = ALU_AND;
                                                FN_OR:   alu_control = ALU_OR;
                                                FN_XOR:  alu_control = ALU_XOR;
                                                FN_NOR:  alu_control = ALU_NOR;
                                                FN_SLT:  alu_control = ALU_SLT;
                                                FN_SLTU: alu_control = ALU_SLTU;
                                                FN_SLL:  alu_control = ALU_SLL;
                                                FN_SRL:  alu_control = ALU_SRL;
                                                FN_SRA:  alu_control = ALU_SRA;
                                                FN_SLLV: alu_control = ALU_SLLV;
                                                FN_SRLV: alu_control = ALU_SRLV;
                                                FN_SRAV: alu_control = ALU_SRAV;
                                                default: alu_control = ALU_ADD;
                                        endcase
                                        // signed add/sub trap, the u-forms wrap
                                        overflow_check = (funct == FN_ADD) ||
                                                         (funct == FN_SUB);
                                end
                                default: alu_control = ALU_ADD; // unused class
                        endcase
                end
        end

endmodule

// File: design/funct_decoder.sv
module funct_decoder import ctrl_pkg::*; (
        input  funct_e funct,
        input  logic   r_type,
        output logic   jump_rt,
        output logic   reg_write_block,
        output logic   mfhi,
        output logic   mflo,
        output logic   mthi,
        output logic   mtlo,
        output logic   mult,
        output logic   multu,
        output logic   div,
        output logic   divu,
        output logic   syscall,
        output logic   brk
);

        always_comb begin
                jump_rt         = 1'b0;
                reg_write_block = 1'b0;
                mfhi            = 1'b0;
                mflo            = 1'b0;
                mthi            = 1'b0;
                mtlo            = 1'b0;
                mult            = 1'b0;
                multu           = 1'b0;
                div             = 1'b0;
                divu            = 1'b0;
                syscall         = 1'b0;
                brk             = 1'b0;

                if (r_type) begin
                        case (funct)
                                FN_JR: begin
                                        jump_rt         = 1'b1;
                                        reg_write_block = 1'b1; // only reads rs
                                end
                                FN_JALR:    jump_rt = 1'b1; // links into rd
                                FN_MFHI:    mfhi    = 1'b1;
                                FN_MFLO:    mflo    = 1'b1;
                                FN_MTHI:    mthi    = 1'b1;
                                FN_MTLO:    mtlo    = 1'b1;
                                // mul/div results land in both hi and lo
                                FN_MULT, FN_MULTU, FN_DIV, FN_DIVU: begin
                                        mthi  = 1'b1;
                                        mtlo  = 1'b1;
                                        mult  = (funct == FN_MULT);
                                        multu = (funct == FN_MULTU);
                                        div   = (funct == FN_DIV);
                                        divu  = (funct == FN_DIVU);
                                end
                                FN_SYSCALL: syscall = 1'b1;
                                FN_BREAK:   brk     = 1'b1;
                                default: ; // plain alu ops
                        endcase
                end
        end

endmodule

// File: design/main_decoder.sv
module main_decoder import ctrl_pkg::*; (
        input  opcode_e opcode,
        output logic    r_type,
        output logic    reg_write,
        output logic    reg_dst, // 1 = rd, 0 = rt
        output logic    alu_src, // 1 = immediate
        output logic    branch,
        output logic    mem_write,
        output logic    mem_to_reg,
        output logic    jump,
        output logic    lb,
        output logic    lbu,
        output logic    lh,
        output logic    lhu,
        output logic    sb,
        output logic    sh,
        output logic    undefined_instr,
        output alu_op_e alu_op,
        output imm_op_e imm_op
);

        always_comb begin
                r_type          = 1'b0;
                reg_write       = 1'b0;
                reg_dst         = 1'b0;
                alu_src         = 1'b0;
                branch          = 1'b0;
                mem_write       = 1'b0;
                mem_to_reg      = 1'b0;
                jump            = 1'b0;
                lb              = 1'b0;
                lbu             = 1'b0;
                lh              = 1'b0;
                lhu             = 1'b0;
                sb              = 1'b0;
                sh              = 1'b0;
                undefined_instr = 1'b0;
                alu_op          = ALU_OP_ADD;
                imm_op          = IMM_NONE;

                case (opcode)
                        OP_RTYPE: begin
                                r_type    = 1'b1;
                                reg_write = 1'b1; // jr masks this at the top
                                reg_dst   = 1'b1;
                                alu_op    = ALU_OP_RTYPE;
                        end

                        OP_LW, OP_LB, OP_LBU, OP_LH, OP_LHU: begin
                                reg_write  = 1'b1;
                                alu_src    = 1'b1;
                                mem_to_reg = 1'b1;
                                lb         = (opcode == OP_LB);
                                lbu        = (opcode == OP_LBU);
                                lh         = (opcode == OP_LH);
                                lhu        = (opcode == OP_LHU);
                        end

                        OP_SW, OP_SB, OP_SH: begin
                                alu_src   = 1'b1;
                                mem_write = 1'b1;
                                sb        = (opcode == OP_SB);
                                sh        = (opcode == OP_SH);
                        end

                        // lui shifts the immediate in the datapath, alu just adds
                        OP_ADDI, OP_ADDIU, OP_LUI: begin
                                reg_write = 1'b1;
                                alu_src   = 1'b1;
                        end

                        OP_ANDI: begin
                                reg_write = 1'b1;
                                alu_src   = 1'b1;
                                imm_op    = IMM_AND;
                        end

                        OP_ORI: begin
                                reg_write = 1'b1;
                                alu_src   = 1'b1;
                                imm_op    = IMM_OR;
                        end

                        OP_XORI: begin
                                reg_write = 1'b1;
                                alu_src   = 1'b1;
                                imm_op    = IMM_XOR;
                        end

                        OP_SLTI: begin
                                reg_write = 1'b1;
                                alu_src   = 1'b1;
                                imm_op    = IMM_SLT;
                        end

                        OP_SLTIU: begin
                                reg_write = 1'b1;
                                alu_src   = 1'b1;
                                imm_op    = IMM_SLTU;
                        end

                        OP_BEQ, OP_BNE, OP_REGIMM, OP_BLEZ, OP_BGTZ: begin
                                branch = 1'b1;
                                alu_op = ALU_OP_SUB; // compare by subtract
                        end

                        OP_J: begin
                                jump = 1'b1;
                        end

                        OP_JAL: begin
                                jump      = 1'b1;
                                reg_write = 1'b1; // link into ra
                        end

                        default: begin
                                undefined_instr = 1'b1;
                        end
                endcase
        end

endmodule

// File: design/ctrl_pkg.sv
`include "ctrl_params.svh"

package ctrl_pkg;

        typedef enum logic [`CTRL_OPCODE_W-1:0] {
                OP_RTYPE  = 6'b000000,
                OP_REGIMM = 6'b000001, // bltz / bgez
                OP_J      = 6'b000010,
                OP_JAL    = 6'b000011,
                OP_BEQ    = 6'b000100,
                OP_BNE    = 6'b000101,
                OP_BLEZ   = 6'b000110,
                OP_BGTZ   = 6'b000111,
                OP_ADDI   = 6'b001000,
                OP_ADDIU  = 6'b001001,
                OP_SLTI   = 6'b001010,
                OP_SLTIU  = 6'b001011,
                OP_ANDI   = 6'b001100,
                OP_ORI    = 6'b001101,
                OP_XORI   = 6'b001110,
                OP_LUI    = 6'b001111,
                OP_LB     = 6'b100000,
                OP_LH     = 6'b100001,
                OP_LW     = 6'b100011,
                OP_LBU    = 6'b100100,
                OP_LHU    = 6'b100101,
                OP_SB     = 6'b101000,
                OP_SH     = 6'b101001,
                OP_SW     = 6'b101011
        } opcode_e;

        typedef enum logic [`CTRL_FUNCT_W-1:0] {
                FN_SLL     = 6'b000000,
                FN_SRL     = 6'b000010,
                FN_SRA     = 6'b000011,
                FN_SLLV    = 6'b000100,
                FN_SRLV    = 6'b000110,
                FN_SRAV    = 6'b000111,
                FN_JR      = 6'b001000,
                FN_JALR    = 6'b001001,
                FN_SYSCALL = 6'b001100,
                FN_BREAK   = 6'b001101,
                FN_MFHI    = 6'b010000,
                FN_MTHI    = 6'b010001,
                FN_MFLO    = 6'b010010,
                FN_MTLO    = 6'b010011,
                FN_MULT    = 6'b011000,
                FN_MULTU   = 6'b011001,
                FN_DIV     = 6'b011010,
                FN_DIVU    = 6'b011011,
                FN_ADD     = 6'b100000,
                FN_ADDU    = 6'b100001,
                FN_SUB     = 6'b100010,
                FN_SUBU    = 6'b100011,
                FN_AND     = 6'b100100,
                FN_OR      = 6'b100101,
                FN_XOR     = 6'b100110,
                FN_NOR     = 6'b100111,
                FN_SLT     = 6'b101010,
                FN_SLTU    = 6'b101011
        } funct_e;

        typedef enum logic [`CTRL_ALU_OP_W-1:0] {
                ALU_OP_ADD   = 2'b00, // address calc, add-type immediates
                ALU_OP_SUB   = 2'b01, // branch compare
                ALU_OP_RTYPE = 2'b10  // look at funct
        } alu_op_e;

        typedef enum logic [`CTRL_IMM_OP_W-1:0] {
                IMM_NONE = 3'b000,
                IMM_AND  = 3'b001,
                IMM_OR   = 3'b010,
                IMM_XOR  = 3'b011,
                IMM_SLT  = 3'b100,
                IMM_SLTU = 3'b101
        } imm_op_e;

        typedef enum logic [`CTRL_ALU_CTRL_W-1:0] {
                ALU_AND  = 4'b0000,
                ALU_OR   = 4'b0001,
                ALU_ADD  = 4'b0010,
                ALU_XOR  = 4'b0100,
                ALU_NOR  = 4'b0101,
                ALU_SUB  = 4'b0110,
                ALU_SLT  = 4'b0111,
                ALU_SLTU = 4'b1000,
                ALU_SLL  = 4'b1001,
                ALU_SRL  = 4'b1010,
                ALU_SRA  = 4'b1011,
                ALU_SLLV = 4'b1100,
                ALU_SRLV = 4'b1101,
                ALU_SRAV = 4'b1110
        } alu_ctrl_e;

endpackage

// File: include/ctrl_params.svh
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

// instruction field widths
`define CTRL_OPCODE_W 6 // instr[31:26]
`define CTRL_FUNCT_W 6 // instr[5:0], r-type only

// internal decode widths
`define CTRL_ALU_OP_W 2 // alu class, main -> alu decoder
`define CTRL_IMM_OP_W 3 // immediate alu operation

// datapath control
`define CTRL_ALU_CTRL_W 4 // alu function select

`endif
